//--- include/branch_config.svh
`ifndef BRANCH_CONFIG_SVH
`define BRANCH_CONFIG_SVH

// width of the register operands and of every pc in the branch path
`define XLEN 32

// log2 of the btb entry count
// the index comes from pc bits [BTB_INDEX_BITS+1:2] since instructions are word aligned
`define BTB_INDEX_BITS 4

`endif

//--- src/branch_pkg.sv
`include "branch_config.svh"

package branch_pkg;

  // major opcode shared by all conditional branches
  localparam logic [6:0] BRANCH_OPCODE = 7'b1100011;

  // register-format field layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rtype_t;

  // branch-format layout, the immediate is scattered over the word
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } btype_t;

  typedef union packed {
    rtype_t rtype;
    btype_t btype;
  } instr_word_t;

  // compare performed by the resolution stage, funct3 bit 0 inverts it
  typedef enum logic [1:0] {
    cmp_eq  = 2'd0,
    cmp_lt  = 2'd1,
    cmp_ltu = 2'd2
  } cmp_kind_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    instr_word_t      instr;
    logic [`XLEN-1:0] reg_a;
    logic [`XLEN-1:0] reg_b;
  } issue_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] reg_a;
    logic [`XLEN-1:0] reg_b;
    logic [`XLEN-1:0] imm;
    cmp_kind_t        cmp_kind;
    logic             invert;
    logic             is_branch;
  } decoded_t;

  typedef struct packed {
    decoded_t         dec;
    logic             predicted_taken;
    logic [`XLEN-1:0] predicted_target;
  } predicted_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic             is_branch;
    logic             taken;
    logic             mispredict;
    logic [`XLEN-1:0] correct_pc;
    logic [`XLEN-1:0] target;
  } resolve_t;

  // training record sent back from resolution to the btb
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic             taken;
    logic [`XLEN-1:0] target;
  } btb_update_t;

endpackage

//--- src/branch_decode.sv
`timescale 1ns/1ps
`include "branch_config.svh"

module branch_decode (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 issue_valid,
  input  branch_pkg::issue_t   issue,
  output logic                 dec_valid,
  output branch_pkg::decoded_t dec
);
  import branch_pkg::*;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  btype_t           bfields;
  logic [`XLEN-1:0] imm;
  cmp_kind_t        cmp_kind;
  logic             invert;
  logic             is_branch;

  always_comb begin
    // opcode and funct3 sit in the same place in both views
    opcode  = issue.instr.rtype.opcode;
    funct3  = issue.instr.rtype.funct3;
    bfields = issue.instr.btype;

    // 13-bit immediate, bit 0 is always zero
    imm = {{(`XLEN-13){bfields.imm12}},
           bfields.imm12,
           bfields.imm11,
           bfields.imm10_5,
           bfields.imm4_1,
           1'b0};

    // funct3[2:1] picks the compare, funct3[0] flips it
    case (funct3[2:1])
      2'b00:   cmp_kind = cmp_eq;
      2'b10:   cmp_kind = cmp_lt;
      2'b11:   cmp_kind = cmp_ltu;
      default: cmp_kind = cmp_eq;
    endcase
    invert = funct3[0];

    // 010 and 011 are reserved encodings under the branch opcode
    is_branch = (opcode == BRANCH_OPCODE) && (funct3[2:1] != 2'b01);
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= issue_valid;
    end
  end

  // payload only moves with a strobe
  always_ff @(posedge CLK) begin
    if (issue_valid) begin
      dec.pc        <= issue.pc;
      dec.reg_a     <= issue.reg_a;
      dec.reg_b     <= issue.reg_b;
      dec.imm       <= imm;
      dec.cmp_kind  <= cmp_kind;
      dec.invert    <= invert;
      dec.is_branch <= is_branch;
    end
  end

endmodule

//--- src/branch_predictor.sv
`timescale 1ns/1ps
`include "branch_config.svh"

module branch_predictor (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    dec_valid,
  input  branch_pkg::decoded_t    dec,
  input  logic                    upd_valid,
  input  branch_pkg::btb_update_t upd,
  output logic                    pred_valid,
  output branch_pkg::predicted_t  pred
);
  import branch_pkg::*;

  localparam int ENTRIES  = 1 << `BTB_INDEX_BITS;
  localparam int TAG_BITS = `XLEN - `BTB_INDEX_BITS - 2;

  // direct-mapped table
  logic [ENTRIES-1:0]  btb_valid;
  logic [TAG_BITS-1:0] btb_tag    [ENTRIES];
  logic [`XLEN-1:0]    btb_target [ENTRIES];
  logic [1:0]          btb_ctr    [ENTRIES];

  logic [`BTB_INDEX_BITS-1:0] look_idx;
  logic [TAG_BITS-1:0]        look_tag;
  logic                       look_hit;
  logic                       look_taken;
  logic [`XLEN-1:0]           look_target;

  logic [`BTB_INDEX_BITS-1:0] upd_idx;
  logic [TAG_BITS-1:0]        upd_tag;
  logic                       upd_hit;

  // lookup reads the table as it stands before this edge's update
  always_comb begin
    look_idx    = dec.pc[`BTB_INDEX_BITS+1:2];
    look_tag    = dec.pc[`XLEN-1:`BTB_INDEX_BITS+2];
    look_hit    = btb_valid[look_idx] && (btb_tag[look_idx] == look_tag);
    // weakly or strongly taken
    look_taken  = look_hit && btb_ctr[look_idx][1];
    look_target = look_taken ? btb_target[look_idx] : dec.pc + `XLEN'd4;
  end

  always_comb begin
    upd_idx = upd.pc[`BTB_INDEX_BITS+1:2];
    upd_tag = upd.pc[`XLEN-1:`BTB_INDEX_BITS+2];
    upd_hit = btb_valid[upd_idx] && (btb_tag[upd_idx] == upd_tag);
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      btb_valid <= '0;
      for (int i = 0; i < ENTRIES; i++) begin
        btb_ctr[i] <= 2'd0;
      end
    end else if (upd_valid) begin
      if (upd_hit) begin
        // saturating 2-bit counter
        if (upd.taken && btb_ctr[upd_idx] != 2'd3) begin
          btb_ctr[upd_idx] <= btb_ctr[upd_idx] + 2'd1;
        end else if (!upd.taken && btb_ctr[upd_idx] != 2'd0) begin
          btb_ctr[upd_idx] <= btb_ctr[upd_idx] - 2'd1;
        end
      end else if (upd.taken) begin
        // allocate weakly taken, a not-taken miss leaves the entry alone
        btb_valid[upd_idx] <= 1'b1;
        btb_ctr[upd_idx]   <= 2'd2;
      end
    end
  end

  // on a hit the tag is rewritten with its own value
  always_ff @(posedge CLK) begin
    if (upd_valid && upd.taken) begin
      btb_tag[upd_idx]    <= upd_tag;
      btb_target[upd_idx] <= upd.target;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pred_valid <= 1'b0;
    end else begin
      pred_valid <= dec_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (dec_valid) begin
      pred.dec              <= dec;
      pred.predicted_taken  <= look_taken;
      pred.predicted_target <= look_target;
    end
  end

endmodule

//--- src/fu_branch.sv
`timescale 1ns/1ps
`include "branch_config.svh"

module fu_branch (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    pred_valid,
  input  branch_pkg::predicted_t  pred,
  output logic                    result_valid,
  output branch_pkg::resolve_t    result,
  output logic                    upd_valid,
  output branch_pkg::btb_update_t upd
);
  import branch_pkg::*;

  logic             cmp_true;
  logic             taken;
  logic [`XLEN-1:0] target;
  logic [`XLEN-1:0] correct_pc;
  logic             target_wrong;
  logic             mispredict;

  always_comb begin
    case (pred.dec.cmp_kind)
      cmp_eq:  cmp_true = (pred.dec.reg_a == pred.dec.reg_b);
      cmp_lt:  cmp_true = ($signed(pred.dec.reg_a) < $signed(pred.dec.reg_b));
      cmp_ltu: cmp_true = (pred.dec.reg_a < pred.dec.reg_b);
      default: cmp_true = 1'b0;
    endcase
  end

  always_comb begin
    // non-branch words never take
    taken      = pred.dec.is_branch && (cmp_true ^ pred.dec.invert);
    target     = pred.dec.pc + pred.dec.imm;
    correct_pc = taken ? target : pred.dec.pc + `XLEN'd4;

    // a right direction can still carry a stale target
    target_wrong = taken && pred.predicted_taken && (pred.predicted_target != target);
    mispredict   = (taken != pred.predicted_taken) || target_wrong;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= pred_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (pred_valid) begin
      result.pc         <= pred.dec.pc;
      result.is_branch  <= pred.dec.is_branch;
      result.taken      <= taken;
      result.mispredict <= mispredict;
      result.correct_pc <= correct_pc;
      result.target     <= target;
    end
  end

  // training goes out alongside the result, only for real branches
  always_comb begin
    upd_valid  = result_valid && result.is_branch;
    upd.pc     = result.pc;
    upd.taken  = result.taken;
    upd.target = result.target;
  end

endmodule

//--- src/branch_unit_top.sv
`timescale 1ns/1ps

module branch_unit_top (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 issue_valid,
  input  branch_pkg::issue_t   issue,
  output logic                 result_valid,
  output branch_pkg::resolve_t result
);
  import branch_pkg::*;

  // decode to predictor
  logic        dec_valid;
  decoded_t    dec;

  // predictor to resolution
  logic        pred_valid;
  predicted_t  pred;

  // training loop from resolution back to the btb
  logic        upd_valid;
  btb_update_t upd;

  branch_decode decode_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .issue_valid (issue_valid),
    .issue       (issue),
    .dec_valid   (dec_valid),
    .dec         (dec)
  );

  branch_predictor predictor_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .dec_valid  (dec_valid),
    .dec        (dec),
    .upd_valid  (upd_valid),
    .upd        (upd),
    .pred_valid (pred_valid),
    .pred       (pred)
  );

  fu_branch resolve_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .pred_valid   (pred_valid),
    .pred         (pred),
    .result_valid (result_valid),
    .result       (result),
    .upd_valid    (upd_valid),
    .upd          (upd)
  );

endmodule

//--- bench/branch_unit_properties.sv
`timescale 1ns/1ps

module branch_unit_properties (
  input logic        CLK,
  input logic        nRST,
  input logic        issue_valid,
  input logic [31:0] issue_word,
  input logic        result_valid,
  input logic        upd_valid
);
  import branch_pkg::*;

  logic branch_word;

  // reserved funct3 010 and 011 do not count as branches
  assign branch_word = (issue_word[6:0] == BRANCH_OPCODE) && (issue_word[14:13] != 2'b01);

  // fixed three-stage latency in both directions
  assert property (@(posedge CLK) disable iff (!nRST)
    issue_valid |-> ##3 result_valid)
    else $error("result_valid missing three cycles after issue_valid");

  assert property (@(posedge CLK) disable iff (!nRST)
    result_valid |-> $past(issue_valid, 3))
    else $error("result_valid without an issue three cycles earlier");

  // in-flight work is gone once reset lifts
  assert property (@(posedge CLK)
    $rose(nRST) |-> !result_valid ##1 !result_valid ##1 !result_valid)
    else $error("result_valid high within three cycles after reset");

  // training goes with the result of a real branch and nothing else
  assert property (@(posedge CLK) disable iff (!nRST)
    upd_valid == (result_valid && $past(branch_word, 3)))
    else $error("upd_valid does not match the word issued three cycles earlier");

endmodule

bind branch_unit_top branch_unit_properties props_i (
  .CLK          (CLK),
  .nRST         (nRST),
  .issue_valid  (issue_valid),
  .issue_word   (issue.instr),
  .result_valid (result_valid),
  .upd_valid    (upd_valid)
);

//--- bench/branch_unit_tb.sv
`timescale 1ns/1ps
`include "branch_config.svh"

module branch_unit_tb;
  import branch_pkg::*;

  typedef struct packed {
    logic        do_reset;
    logic [31:0] pc;
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [1:0]  exp_taken;
    logic [3:0]  gap;
  } stim_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [1:0]  exp_taken;
    logic        pt;
    logic [31:0] ptgt;
  } slot_t;

  typedef struct packed {
    resolve_t   r;
    logic [1:0] exp_taken;
  } expect_t;

  logic     CLK;
  logic     nRST;
  logic     issue_valid;
  issue_t   issue;
  logic     result_valid;
  resolve_t result;

  // hand-written direction that rides along with each strobe
  logic [1:0] issue_exp_taken;

  stim_t    table_q[$];
  expect_t  exp_q[$];
  int       errors;
  int       cycles;
  int       limit;
  logic [15:0] lfsr_state;

  // reference btb
  logic        m_valid [16];
  logic [25:0] m_tag   [16];
  logic [31:0] m_tgt   [16];
  logic [1:0]  m_ctr   [16];
  slot_t       s1, s2, s3;

  branch_unit_top dut_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .result_valid (result_valid),
    .result       (result)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // galois lfsr, one step per bit
  function automatic logic next_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] imm_of(input logic [31:0] w);
    return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  function automatic logic word_is_branch(input logic [31:0] w);
    return (w[6:0] == 7'b1100011) && (w[14:13] != 2'b01);
  endfunction

  // taken by the b-type compare rules
  function automatic logic rule_taken(input logic [31:0] w, input logic [31:0] a,
                                      input logic [31:0] b);
    logic c;
    case (w[14:13])
      2'b00:   c = (a == b);
      2'b10:   c = ($signed(a) < $signed(b));
      2'b11:   c = (a < b);
      default: c = 1'b0;
    endcase
    return word_is_branch(w) && (c ^ w[12]);
  endfunction

  task automatic add_row(input logic [31:0] pc, input logic [31:0] w, input logic [31:0] a,
                         input logic [31:0] b, input logic [1:0] et, input int gap);
    table_q.push_back('{1'b0, pc, w, a, b, et, gap[3:0]});
  endtask

  task automatic add_reset();
    table_q.push_back('{1'b1, 32'd0, 32'd0, 32'd0, 32'd0, 2'd2, 4'd0});
  endtask

  task automatic build_table();
    logic [2:0] f3_list [6];
    f3_list = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    // all six compares back to back
    add_row(32'h1000, enc_branch(3'b000, 13'd16), 32'd5, 32'd5, 2'd1, 0);
    add_row(32'h1004, enc_branch(3'b001, 13'd16), 32'd5, 32'd5, 2'd0, 0);
    add_row(32'h1008, enc_branch(3'b100, 13'd24), -32'sd3, 32'd2, 2'd1, 0);
    add_row(32'h100C, enc_branch(3'b101, 13'd24), -32'sd3, 32'd2, 2'd0, 0);
    add_row(32'h1010, enc_branch(3'b110, -13'sd8), 32'hFFFFFFFF, 32'd1, 2'd0, 0);
    add_row(32'h1014, enc_branch(3'b111, -13'sd8), 32'hFFFFFFFF, 32'd1, 2'd1, 0);
    for (int i = 0; i < 6; i++) begin
      add_row(32'h2018 + 4 * i, enc_branch(f3_list[rand_bits(3) % 6], 13'd32),
              rand_bits(32), rand_bits(32), 2'd2, 0);
    end
    // backward loop branch trains up
    for (int i = 0; i < 4; i++) begin
      add_row(32'h3020, enc_branch(3'b001, -13'sd32), 32'd1, 32'd2, 2'd1, 3);
    end
    // same branch falls through, counter walks down
    for (int i = 0; i < 4; i++) begin
      add_row(32'h3020, enc_branch(3'b001, -13'sd32), 32'd7, 32'd7, 2'd0, 3);
    end
    // aliasing pair on index 12
    for (int i = 0; i < 4; i++) begin
      add_row(32'h4030, enc_branch(3'b000, 13'd64), 32'd9, 32'd9, 2'd1, 3);
      add_row(32'h5030, enc_branch(3'b000, 13'd128), 32'd9, 32'd9, 2'd1, 3);
    end
    // train, then words that are not branches, then the branch again
    add_row(32'h6024, enc_branch(3'b100, 13'd40), 32'd1, 32'd3, 2'd1, 3);
    add_row(32'h6024, enc_branch(3'b100, 13'd40), 32'd1, 32'd3, 2'd1, 3);
    add_row(32'h6024, 32'h00208033, 32'd1, 32'd3, 2'd0, 3);
    add_row(32'h6024, {17'h0, 3'b010, 12'h063}, 32'd1, 32'd1, 2'd0, 3);
    add_row(32'h6024, enc_branch(3'b100, 13'd40), 32'd1, 32'd3, 2'd1, 3);
    // reset with branches still in flight
    add_row(32'h3020, enc_branch(3'b001, -13'sd32), 32'd1, 32'd2, 2'd1, 0);
    add_row(32'h3020, enc_branch(3'b001, -13'sd32), 32'd1, 32'd2, 2'd1, 0);
    add_reset();
    add_row(32'h3020, enc_branch(3'b001, -13'sd32), 32'd1, 32'd2, 2'd1, 3);
    add_row(32'h3020, enc_branch(3'b001, -13'sd32), 32'd1, 32'd2, 2'd1, 3);
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    nRST        <= 1'b0;
    issue_valid <= 1'b0;
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
  endtask

  task automatic issue_row(input stim_t s);
    @(posedge CLK);
    issue_valid     <= 1'b1;
    issue.pc        <= s.pc;
    issue.instr     <= s.word;
    issue.reg_a     <= s.a;
    issue.reg_b     <= s.b;
    issue_exp_taken <= s.exp_taken;
    for (int i = 0; i < s.gap; i++) begin
      @(posedge CLK);
      issue_valid <= 1'b0;
    end
  endtask

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  // reference pipeline, stepped at every edge like the dut
  always @(posedge CLK or negedge nRST) begin
    logic [3:0] idx;
    expect_t    e;
    if (!nRST) begin
      for (int i = 0; i < 16; i++) begin
        m_valid[i] = 1'b0;
        m_ctr[i]   = 2'd0;
      end
      s1 = '0;
      s2 = '0;
      s3 = '0;
      exp_q.delete();
    end else begin
      // lookup sees the table before this edge's training
      idx   = s1.pc[5:2];
      s1.pt = m_valid[idx] && (m_tag[idx] == s1.pc[31:6]) && (m_ctr[idx] >= 2);
      s1.ptgt = s1.pt ? m_tgt[idx] : s1.pc + 32'd4;
      if (s3.valid && word_is_branch(s3.word)) begin
        idx = s3.pc[5:2];
        if (m_valid[idx] && m_tag[idx] == s3.pc[31:6]) begin
          if (rule_taken(s3.word, s3.a, s3.b)) begin
            m_tgt[idx] = s3.pc + imm_of(s3.word);
            if (m_ctr[idx] != 2'd3) m_ctr[idx] = m_ctr[idx] + 2'd1;
          end else if (m_ctr[idx] != 2'd0) begin
            m_ctr[idx] = m_ctr[idx] - 2'd1;
          end
        end else if (rule_taken(s3.word, s3.a, s3.b)) begin
          m_valid[idx] = 1'b1;
          m_tag[idx]   = s3.pc[31:6];
          m_tgt[idx]   = s3.pc + imm_of(s3.word);
          m_ctr[idx]   = 2'd2;
        end
      end
      s3 = s2;
      s2 = s1;
      s1 = {issue_valid, issue.pc, issue.instr, issue.reg_a, issue.reg_b, issue_exp_taken,
            1'b0, 32'd0};
      if (s3.valid) begin
        e.r.pc         = s3.pc;
        e.r.is_branch  = word_is_branch(s3.word);
        e.r.taken      = rule_taken(s3.word, s3.a, s3.b);
        e.r.target     = s3.pc + imm_of(s3.word);
        e.r.correct_pc = e.r.taken ? e.r.target : s3.pc + 32'd4;
        e.r.mispredict = (e.r.taken != s3.pt) || (e.r.taken && s3.pt && s3.ptgt != e.r.target);
        e.exp_taken    = s3.exp_taken;
        exp_q.push_back(e);
      end
    end
  end

  // outputs are stable at the falling edge
  always @(negedge CLK) begin
    expect_t e;
    if (nRST) begin
      if (result_valid !== s3.valid) begin
        check_field("result_valid", {31'd0, s3.valid}, {31'd0, result_valid});
      end else if (result_valid) begin
        if (exp_q.size() == 0) begin
          $display("result came out with no branch expected at %0t", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          check_field("result.pc", e.r.pc, result.pc);
          check_field("result.is_branch", {31'd0, e.r.is_branch}, {31'd0, result.is_branch});
          check_field("result.taken", {31'd0, e.r.taken}, {31'd0, result.taken});
          check_field("result.mispredict", {31'd0, e.r.mispredict}, {31'd0, result.mispredict});
          check_field("result.correct_pc", e.r.correct_pc, result.correct_pc);
          check_field("result.target", e.r.target, result.target);
          if (e.exp_taken != 2'd2) begin
            check_field("result.taken vs table", {30'd0, e.exp_taken}, {31'd0, result.taken});
          end
        end
      end
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, results did not drain", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    errors          = 0;
    cycles          = 0;
    limit           = 0;
    lfsr_state      = 16'd42693;
    nRST            = 1'b0;
    issue_valid     = 1'b0;
    issue           = '0;
    issue_exp_taken = 2'd2;
    build_table();
    limit = 50;
    foreach (table_q[i]) begin
      limit += table_q[i].gap + 4;
    end
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    foreach (table_q[i]) begin
      if (table_q[i].do_reset) begin
        apply_reset();
      end else begin
        issue_row(table_q[i]);
      end
    end
    @(posedge CLK);
    issue_valid <= 1'b0;
    while (s1.valid || s2.valid || s3.valid || exp_q.size() > 0) begin
      @(posedge CLK);
    end
    @(negedge CLK);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
src/branch_pkg.sv
src/branch_decode.sv
src/branch_predictor.sv
src/fu_branch.sv
src/branch_unit_top.sv
bench/branch_unit_properties.sv
bench/branch_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module branch_unit_tb \
  -o branch_unit_sim

sim_out="$(./obj_dir/branch_unit_sim)"
echo "$sim_out"

if grep -q "Simulation completed successfully" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi
